/* Bender.yml */
package:
  name: capture_stream

sources:
  - hdl/sample_pkg.sv
  - hdl/stream_pkg.sv
  - hdl/capture_ctrl.sv
  - hdl/route_config.sv
  - hdl/word_router.sv
  - hdl/beat_fifo.sv
  - hdl/stream_out.sv
  - hdl/capture_stream_top.sv
  - target: test
    files:
      - tb/tb_capture_stream.sv

/* hdl/beat_fifo.sv */
module beat_fifo (
  input  logic              clk_245_76MHz,
  input  logic              rst_n,
  input  stream_pkg::beat_t wr_beat,
  input  logic              wr_en,
  input  logic              rd_en,
  output stream_pkg::beat_t rd_beat,
  output logic              fifo_empty,
  output logic              overflow
);

  import stream_pkg::*;

  beat_t     mem [FIFO_DEPTH]; // storage, no reset needed
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t fill;
  logic      full;
  logic      do_wr;
  logic      do_rd;

  assign full       = (fill == fifo_cnt_t'(FIFO_DEPTH));
  assign fifo_empty = (fill == '0);
  assign do_wr      = wr_en & ~full;  // full drops the beat
  assign do_rd      = rd_en & ~fifo_empty;
  assign rd_beat    = mem[rd_ptr];    // head shows without a read

  always_ff @(posedge clk_245_76MHz) begin
    if (do_wr)
      mem[wr_ptr] <= wr_beat;
  end

  // pointers wrap on their own at depth 16
  always_ff @(posedge clk_245_76MHz) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill; // none or both
      endcase
    end
  end

  // sticky until reset
  always_ff @(posedge clk_245_76MHz) begin
    if (!rst_n)
      overflow <= 1'b0;
    else if (wr_en && full)
      overflow <= 1'b1;
  end

  // the output stage must not pop an empty buffer
  no_empty_read: assert property (
    @(posedge clk_245_76MHz) disable iff (!rst_n)
    rd_en |-> !fifo_empty
  ) else $error("beat fifo read while empty");

endmodule

/* hdl/capture_ctrl.sv */
module capture_ctrl (
  input  logic clk_245_76MHz,
  input  logic rst_n,
  input  logic adc_enable,
  input  logic chirp_init,
  output logic capture_gate,
  output logic capture_done
);

  import sample_pkg::*;

  logic     enable_r; // first stage, plain alignment
  lat_cnt_t lat_cnt;  // nonzero while the dds output settles

  wire lat_idle = (lat_cnt == '0);

  // latency window, reloaded on every chirp start
  always_ff @(posedge clk_245_76MHz) begin
    if (!rst_n) begin
      lat_cnt <= '0;
    end else if (chirp_init) begin
      lat_cnt <= lat_cnt_t'(DDS_LATENCY - 1);
    end else if (!lat_idle) begin
      lat_cnt <= lat_cnt - 1'b1; // count down to idle
    end
  end

  // enable pipe, second stage frozen during the window
  always_ff @(posedge clk_245_76MHz) begin
    if (!rst_n) begin
      enable_r     <= 1'b0;
      capture_gate <= 1'b0;
      capture_done <= 1'b0;
    end else begin
      enable_r <= adc_enable;
      if (lat_idle)
        capture_gate <= enable_r; // else hold
      capture_done <= enable_r & ~adc_enable; // falling edge of enable
    end
  end

  // end of capture is a single strobe
  done_one_cycle: assert property (
    @(posedge clk_245_76MHz) disable iff (!rst_n)
    capture_done |=> !capture_done
  ) else $error("capture_done longer than one cycle");

  // gate must not move while the chirp core is settling
  gate_frozen: assert property (
    @(posedge clk_245_76MHz) disable iff (!rst_n)
    !lat_idle |=> $stable(capture_gate)
  ) else $error("capture_gate changed inside dds latency window");

endmodule

/* hdl/capture_stream_top.sv */
module capture_stream_top (
  input  logic                   clk_245_76MHz,
  input  logic                   rst_n,
  input  logic [15:0]            adc_i,
  input  logic [15:0]            adc_q,
  input  logic                   adc_valid,
  input  logic [15:0]            dac_i,
  input  logic [15:0]            dac_q,
  input  sample_pkg::count_t     adc_counter,
  input  logic                   adc_enable,
  input  logic                   chirp_init,
  input  sample_pkg::ctrl_word_t chirp_control_word,
  output stream_pkg::beat_t      tdata,
  output logic                   tvalid,
  input  logic                   tready,
  output logic                   capture_done,
  output logic                   overflow
);

  import sample_pkg::*;
  import stream_pkg::*;

  logic       capture_gate;
  route_sel_t route_lo;
  route_sel_t route_hi;
  beat_t      wr_beat;  // router to fifo
  logic       wr_en;
  beat_t      rd_beat;  // fifo head
  logic       fifo_empty;
  logic       rd_en;

  capture_ctrl u_capture_ctrl (
    .clk_245_76MHz, .rst_n, .adc_enable, .chirp_init,
    .capture_gate, .capture_done
  );

  route_config u_route_config (
    .clk_245_76MHz, .rst_n, .chirp_init, .chirp_control_word,
    .route_lo, .route_hi
  );

  word_router u_word_router (
    .clk_245_76MHz, .rst_n, .adc_i, .adc_q, .dac_i, .dac_q,
    .adc_counter, .adc_valid, .capture_gate, .route_lo, .route_hi,
    .wr_beat, .wr_en
  );

  beat_fifo u_beat_fifo (
    .clk_245_76MHz, .rst_n, .wr_beat, .wr_en, .rd_en,
    .rd_beat, .fifo_empty, .overflow
  );

  stream_out u_stream_out (
    .clk_245_76MHz, .rst_n, .rd_beat, .fifo_empty, .rd_en,
    .tdata, .tvalid, .tready
  );

endmodule

/* hdl/route_config.sv */
module route_config (
  input  logic                   clk_245_76MHz,
  input  logic                   rst_n,
  input  logic                   chirp_init,
  input  sample_pkg::ctrl_word_t chirp_control_word,
  output sample_pkg::route_sel_t route_lo,
  output sample_pkg::route_sel_t route_hi
);

  import sample_pkg::*;

  localparam int SEL_W = $bits(route_sel_t);

  // fields of the live control word
  route_sel_t next_lo;
  route_sel_t next_hi;

  assign next_lo = chirp_control_word[ROUTE_LO_LSB +: SEL_W];
  assign next_hi = chirp_control_word[ROUTE_HI_LSB +: SEL_W];

  // routing only changes at a chirp start, never mid capture
  always_ff @(posedge clk_245_76MHz) begin
    if (!rst_n) begin
      route_lo <= ROUTE_ADC_IQ; // adc samples on both halves by default
      route_hi <= ROUTE_ADC_IQ;
    end else if (chirp_init) begin
      route_lo <= next_lo;
      route_hi <= next_hi;
    end
  end

endmodule

/* hdl/sample_pkg.sv */
package sample_pkg;

  // one sample word, I in the upper half, Q in the lower half
  typedef logic [31:0] iq_word_t;

  typedef logic [31:0] count_t;     // adc sample count and global cycle count
  typedef logic [1:0]  route_sel_t; // selects the source of one beat half
  typedef logic [3:0]  lat_cnt_t;   // dds latency window counter
  typedef logic [31:0] ctrl_word_t; // chirp control word from the host

  // route codes, one per beat half
  localparam route_sel_t ROUTE_ADC_IQ     = 2'd0;
  localparam route_sel_t ROUTE_DAC_IQ     = 2'd1;
  localparam route_sel_t ROUTE_ADC_COUNT  = 2'd2;
  localparam route_sel_t ROUTE_GLBL_COUNT = 2'd3;

  // field positions inside the control word
  localparam int ROUTE_LO_LSB = 0; // bits 1:0 pick the lower half
  localparam int ROUTE_HI_LSB = 4; // bits 5:4 pick the upper half

  // cycles the chirp core needs before its samples line up
  // with the enable again
  localparam int DDS_LATENCY = 2;

endpackage

/* hdl/stream_out.sv */
module stream_out (
  input  logic              clk_245_76MHz,
  input  logic              rst_n,
  input  stream_pkg::beat_t rd_beat,
  input  logic              fifo_empty,
  output logic              rd_en,
  output stream_pkg::beat_t tdata,
  output logic              tvalid,
  input  logic              tready
);

  logic slot_free; // register empty or being taken this cycle

  assign slot_free = ~tvalid | tready;
  assign rd_en     = slot_free & ~fifo_empty; // pop and load together

  always_ff @(posedge clk_245_76MHz) begin
    if (!rst_n) begin
      tvalid <= 1'b0;
    end else if (rd_en) begin
      tvalid <= 1'b1;
    end else if (tready) begin
      tvalid <= 1'b0; // accepted, nothing behind it
    end
  end

  // data only moves with a load
  always_ff @(posedge clk_245_76MHz) begin
    if (rd_en)
      tdata <= rd_beat;
  end

  // back-pressure holds the beat and its valid
  hold_on_stall: assert property (
    @(posedge clk_245_76MHz) disable iff (!rst_n)
    tvalid && !tready |=> tvalid && $stable(tdata)
  ) else $error("tdata changed while stalled");

endmodule

/* hdl/stream_pkg.sv */
package stream_pkg;

  import sample_pkg::*;

  // one output beat, two 32-bit halves
  typedef struct packed {
    iq_word_t upper; // bits 63:32
    iq_word_t lower; // bits 31:0
  } beat_t;

  // beat FIFO sizing
  localparam int FIFO_DEPTH = 16;

  typedef logic [3:0] fifo_ptr_t; // wraps at FIFO_DEPTH
  typedef logic [4:0] fifo_cnt_t; // 0 .. FIFO_DEPTH inclusive

endpackage

/* hdl/word_router.sv */
module word_router (
  input  logic                   clk_245_76MHz,
  input  logic                   rst_n,
  input  logic [15:0]            adc_i,
  input  logic [15:0]            adc_q,
  input  logic [15:0]            dac_i,
  input  logic [15:0]            dac_q,
  input  sample_pkg::count_t     adc_counter,
  input  logic                   adc_valid,
  input  logic                   capture_gate,
  input  sample_pkg::route_sel_t route_lo,
  input  sample_pkg::route_sel_t route_hi,
  output stream_pkg::beat_t      wr_beat,
  output logic                   wr_en
);

  import sample_pkg::*;
  import stream_pkg::*;

  count_t   glbl_cnt; // free running since reset
  iq_word_t adc_iq;
  iq_word_t dac_iq;
  beat_t    next_beat;

  // 4-way source pick for one half
  function automatic iq_word_t pick_half(route_sel_t sel, iq_word_t a_iq, iq_word_t d_iq,
                                         count_t a_cnt, count_t g_cnt);
    case (sel)
      ROUTE_ADC_IQ:     return a_iq;
      ROUTE_DAC_IQ:     return d_iq;
      ROUTE_ADC_COUNT:  return a_cnt;
      ROUTE_GLBL_COUNT: return g_cnt;
      default:          return a_iq;
    endcase
  endfunction

  assign adc_iq = {adc_i, adc_q}; // i high, q low
  assign dac_iq = {dac_i, dac_q};

  assign next_beat.upper = pick_half(route_hi, adc_iq, dac_iq, adc_counter, glbl_cnt);
  assign next_beat.lower = pick_half(route_lo, adc_iq, dac_iq, adc_counter, glbl_cnt);

  always_ff @(posedge clk_245_76MHz) begin
    if (!rst_n) begin
      glbl_cnt <= '0;
      wr_en    <= 1'b0;
    end else begin
      glbl_cnt <= glbl_cnt + 1'b1;
      wr_en    <= adc_valid & capture_gate; // only samples inside the window
    end
  end

  // payload register, qualified by wr_en
  always_ff @(posedge clk_245_76MHz) begin
    wr_beat <= next_beat;
  end

  // a write always traces back to an open gate one cycle earlier
  wr_needs_gate: assert property (
    @(posedge clk_245_76MHz) disable iff (!rst_n)
    wr_en |-> $past(capture_gate)
  ) else $error("fifo write without capture gate");

endmodule

/* src.f */
hdl/sample_pkg.sv
hdl/stream_pkg.sv
hdl/capture_ctrl.sv
hdl/route_config.sv
hdl/word_router.sv
hdl/beat_fifo.sv
hdl/stream_out.sv
hdl/capture_stream_top.sv
tb/tb_capture_stream.sv

/* tb/tb_capture_stream.sv */
module tb_capture_stream;

  timeunit 1ns;
  timeprecision 1ps;

  import sample_pkg::*;
  import stream_pkg::*;

  localparam int CLK_HALF  = 10;  // 20 ns period
  localparam int RESET_LEN = 16;
  localparam int CAP_LEN   = 12;  // enable high cycles per burst
  localparam int N_BURSTS  = 21;  // 16 routes, glbl, gating, latency, bp, overflow
  localparam int BP_LEN    = 150; // back-pressure burst
  localparam int DRAIN_MAX = 64;  // worst drain per burst
  localparam int STIM_CYCLES = RESET_LEN + N_BURSTS * (CAP_LEN + 12) + BP_LEN + 80;
  localparam int WATCHDOG_NS = (STIM_CYCLES + (N_BURSTS + 2) * DRAIN_MAX) * 2 * CLK_HALF;

  logic       clk_245_76MHz = 1'b0;
  logic       rst_n;
  logic [15:0] adc_i;
  logic [15:0] adc_q;
  logic [15:0] dac_i;
  logic [15:0] dac_q;
  logic       adc_valid;
  count_t     adc_counter;
  logic       adc_enable;
  logic       chirp_init;
  ctrl_word_t chirp_control_word;
  beat_t      tdata;
  logic       tvalid;
  logic       tready;
  logic       capture_done;
  logic       overflow;

  // reference model state
  logic       m_en_r;
  logic       m_gate;     // model of the capture window
  lat_cnt_t   m_lat;
  logic       m_done;
  count_t     m_glbl;
  route_sel_t m_route_lo;
  route_sel_t m_route_hi;

  // scoreboard
  beat_t      exp_q[$];
  beat_t      exp_head;
  logic       head_valid;
  int         n_pushed;
  int         n_accepted;

  capture_stream_top dut (.*);

  always #(CLK_HALF) clk_245_76MHz = ~clk_245_76MHz;

  // source of one beat half, straight from the route code table
  function automatic iq_word_t route_source(route_sel_t sel);
    case (sel)
      ROUTE_DAC_IQ:     return {dac_i, dac_q};
      ROUTE_ADC_COUNT:  return adc_counter;
      ROUTE_GLBL_COUNT: return m_glbl;
      default:          return {adc_i, adc_q}; // ROUTE_ADC_IQ
    endcase
  endfunction

  // gate, done and route model plus the expected beat queue
  always @(posedge clk_245_76MHz) begin
    beat_t b;
    if (!rst_n) begin
      m_en_r     <= 1'b0;
      m_gate     <= 1'b0;
      m_lat      <= '0;
      m_done     <= 1'b0;
      m_glbl     <= '0;
      m_route_lo <= ROUTE_ADC_IQ;
      m_route_hi <= ROUTE_ADC_IQ;
      exp_q.delete();
    end else begin
      m_en_r <= adc_enable;
      if (chirp_init)
        m_lat <= lat_cnt_t'(DDS_LATENCY - 1);
      else if (m_lat != '0)
        m_lat <= m_lat - 1'b1;
      if (m_lat == '0)
        m_gate <= m_en_r; // frozen while the dds settles
      m_done <= m_en_r & ~adc_enable;
      m_glbl <= m_glbl + 1'b1;
      if (chirp_init) begin
        m_route_lo <= chirp_control_word[ROUTE_LO_LSB +: 2];
        m_route_hi <= chirp_control_word[ROUTE_HI_LSB +: 2];
      end
      if (tvalid && tready) begin
        n_accepted++;
        if (exp_q.size() > 0)
          void'(exp_q.pop_front());
      end
      if (adc_valid && m_gate) begin // strobe inside the model window
        b.upper = route_source(m_route_hi);
        b.lower = route_source(m_route_lo);
        exp_q.push_back(b);
        n_pushed++;
      end
    end
    head_valid = (exp_q.size() > 0);
    exp_head   = head_valid ? exp_q[0] : '0;
  end

  task automatic fail_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  accept_expected: assert property (
    @(posedge clk_245_76MHz) disable iff (!rst_n)
    tvalid && tready |-> head_valid
  ) else begin
    $display("a beat was accepted while no beat was expected");
    fail_run();
  end

  beat_match: assert property (
    @(posedge clk_245_76MHz) disable iff (!rst_n)
    tvalid && tready && head_valid |-> tdata == exp_head
  ) else begin
    $display("ERR tdata got 0x%h expected 0x%h", $sampled(tdata), $sampled(exp_head));
    fail_run();
  end

  // stalled beat must hold
  stall_hold: assert property (
    @(posedge clk_245_76MHz) disable iff (!rst_n)
    tvalid && !tready |=> tvalid && $stable(tdata)
  ) else begin
    $display("tdata or tvalid moved while tready was low");
    fail_run();
  end

  done_match: assert property (
    @(posedge clk_245_76MHz) disable iff (!rst_n)
    capture_done == m_done
  ) else begin
    $display("ERR capture_done got 0x%h expected 0x%h", $sampled(capture_done),
             $sampled(m_done));
    fail_run();
  end

  // inputs move 2 ns after the edge
  task automatic tick();
    @(posedge clk_245_76MHz);
    #2;
  endtask

  task automatic drive_cycle(input int valid_pct, input int ready_pct);
    adc_valid = ($urandom % 100) < valid_pct;
    adc_i     = $urandom;
    adc_q     = $urandom;
    dac_i     = $urandom;
    dac_q     = $urandom;
    if (adc_valid)
      adc_counter = adc_counter + 1'b1; // external sample count
    tready = ($urandom % 100) < ready_pct;
    tick();
  endtask

  task automatic start_chirp(input route_sel_t lo, input route_sel_t hi);
    chirp_control_word = $urandom; // junk outside the route fields
    chirp_control_word[ROUTE_LO_LSB +: 2] = lo;
    chirp_control_word[ROUTE_HI_LSB +: 2] = hi;
    chirp_init = 1'b1;
    tick();
    chirp_init = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    tready = 1'b1;
    while (head_valid || tvalid) begin
      if (waited == DRAIN_MAX) begin
        $display("stream did not drain within %0d cycles", DRAIN_MAX);
        fail_run();
      end
      tick();
      waited++;
    end
  endtask

  task automatic capture(input int n_cycles, input int valid_pct, input int ready_pct);
    adc_enable = 1'b1;
    repeat (n_cycles) drive_cycle(valid_pct, ready_pct);
    adc_enable = 1'b0;
    repeat (4) drive_cycle(valid_pct, ready_pct); // strobes while the gate closes
    adc_valid = 1'b0;
    wait_drained();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    fail_run();
  end

  initial begin
    int base_push;
    int base_acc;
    int waited;
    void'($urandom(32'h3b2dbe54));
    rst_n              = 1'b0;
    adc_i              = '0;
    adc_q              = '0;
    dac_i              = '0;
    dac_q              = '0;
    adc_valid          = 1'b0;
    adc_counter        = '0;
    adc_enable         = 1'b0;
    chirp_init         = 1'b0;
    chirp_control_word = '0;
    tready             = 1'b0;
    n_pushed           = 0;
    n_accepted         = 0;
    repeat (RESET_LEN) @(posedge clk_245_76MHz);
    #2;
    rst_n = 1'b1;
    assert (!tvalid && !capture_done && !overflow) else begin
      $display("outputs not low after reset");
      fail_run();
    end

    // every route code on both halves
    for (int hi = 0; hi < 4; hi++) begin
      for (int lo = 0; lo < 4; lo++) begin
        start_chirp(route_sel_t'(lo), route_sel_t'(hi));
        repeat (2) drive_cycle(0, 100); // latency window runs out
        capture(CAP_LEN, 70, 100);
      end
    end
    start_chirp(ROUTE_GLBL_COUNT, ROUTE_GLBL_COUNT); // back to back counter steps
    repeat (2) drive_cycle(0, 100);
    capture(CAP_LEN, 100, 100);

    // strobes with enable low must vanish
    base_push = n_pushed;
    base_acc  = n_accepted;
    repeat (20) drive_cycle(80, 100);
    adc_valid = 1'b0;
    repeat (4) tick();
    assert (n_pushed == base_push && n_accepted == base_acc) else begin
      $display("beats appeared while adc_enable was low");
      fail_run();
    end
    capture(CAP_LEN, 50, 100);
    assert (n_accepted - base_acc == n_pushed - base_push) else begin
      $display("ERR accepted beats 0x%h expected 0x%h", n_accepted - base_acc,
               n_pushed - base_push);
      fail_run();
    end

    // chirp_init one cycle before the aligned enable rises, gate opens an edge later
    adc_enable = 1'b1;
    start_chirp(ROUTE_ADC_IQ, ROUTE_DAC_IQ);
    capture(CAP_LEN, 100, 100);

    // random back-pressure, fifo stays below full
    start_chirp(ROUTE_ADC_IQ, ROUTE_ADC_COUNT);
    repeat (2) drive_cycle(0, 100);
    capture(BP_LEN, 30, 60);
    assert (overflow === 1'b0) else begin
      $display("ERR overflow got 0x%h expected 0x0", overflow);
      fail_run();
    end

    // 30 strobes into a stalled stream
    start_chirp(ROUTE_ADC_IQ, ROUTE_GLBL_COUNT);
    adc_enable = 1'b1;
    repeat (4) drive_cycle(0, 0); // gate opens
    base_push = n_pushed;
    base_acc  = n_accepted;
    repeat (30) drive_cycle(100, 0);
    adc_enable = 1'b0;
    adc_valid  = 1'b0;
    repeat (4) tick();
    assert (n_pushed - base_push == 30 && overflow === 1'b1) else begin
      $display("ERR overflow got 0x%h expected 0x1, strobes 0x%h", overflow,
               n_pushed - base_push);
      fail_run();
    end
    tready = 1'b1;
    waited = 0;
    while (n_accepted - base_acc < 17) begin
      if (waited == DRAIN_MAX) begin
        $display("held beats did not come out after tready rose");
        fail_run();
      end
      tick();
      waited++;
    end
    repeat (20) tick(); // nothing may follow the 17th
    assert (n_accepted - base_acc == 17 && exp_q.size() == 13 && !tvalid) else begin
      $display("ERR accepted beats 0x%h expected 0x11", n_accepted - base_acc);
      fail_run();
    end
    exp_q.delete(); // the dropped strobes
    head_valid = 1'b0;
    tick();

    if (exp_q.size() == 0 && !tvalid && overflow) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("final state wrong, %0d beats left, overflow %0b", exp_q.size(), overflow);
      fail_run();
    end
  end

endmodule
